//--- Bender.yml
package:
  name: sys_monitor

sources:
  - files:
      - hdl/sys_monitor_pkg.sv
      - hdl/sem_inject_seq.sv
      - hdl/seu_event_counter.sv
      - hdl/adc_sensor_poller.sv
      - hdl/sys_monitor_top.sv
  - target: test
    files:
      - tests/tb_adc_drp_model.sv
      - tests/sys_monitor_asserts.sv
      - tests/tb_sys_monitor.sv

//--- hdl/adc_sensor_poller.sv
`timescale 1ns/1ps

module adc_sensor_poller #(
    parameter int DIV_W     = 16,
    parameter int DEN_DELAY = 255
) (
    input  logic                                   clk66m,
    input  logic                                   rst_66m,
    output logic                                   drp_den,
    output logic [sys_monitor_pkg::DRP_ADDR_W-1:0] drp_daddr,
    input  logic                                   drp_drdy,
    input  logic [sys_monitor_pkg::DRP_DATA_W-1:0] drp_do,
    output logic [sys_monitor_pkg::READING_W-1:0]  temperature,
    output logic [sys_monitor_pkg::READING_W-1:0]  vccint,
    output logic [sys_monitor_pkg::READING_W-1:0]  vccaux,
    output logic [sys_monitor_pkg::READING_W-1:0]  vccbram,
    output logic [sys_monitor_pkg::READING_W-1:0]  vpvn,
    output logic [sys_monitor_pkg::READING_W-1:0]  vrefp,
    output logic [sys_monitor_pkg::READING_W-1:0]  vrefn
);
    import sys_monitor_pkg::*;

    logic [DIV_W-1:0]     div_cnt;
    sensor_chan_e         slot;
    logic [READING_W-1:0] result;

    // ************************************************************
    // Pacing and slot walk
    // ************************************************************
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            div_cnt <= '0;
            slot    <= chan_temperature;
        end else begin
            div_cnt <= div_cnt + 1'b1;  // Free running, wraps
            if (div_cnt == '0) begin
                slot <= sensor_chan_e'(slot + 1'b1);    // Unused slot wraps to temperature
            end
        end
    end

    // One read per slot, well clear of the slot change
    assign drp_den   = (div_cnt == DIV_W'(DEN_DELAY));
    assign drp_daddr = sensor_drp_addr(slot);

    // ADC result is MSB aligned, low nibble dropped
    assign result = drp_do[DRP_DATA_W-1 -: READING_W];

    // ************************************************************
    // Reading registers
    // ************************************************************
    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            temperature <= '0;
            vccint      <= '0;
            vccaux      <= '0;
            vccbram     <= '0;
            vpvn        <= '0;
            vrefp       <= '0;
            vrefn       <= '0;
        end else if (drp_drdy) begin
            case (slot)
                chan_temperature: temperature <= result;
                chan_vccint:      vccint      <= result;
                chan_vccaux:      vccaux      <= result;
                chan_vccbram:     vccbram     <= result;
                chan_vpvn:        vpvn        <= result;
                chan_vrefp:       vrefp       <= result;
                chan_vrefn:       vrefn       <= result;
                default: begin
                    // Spare slot, answer is thrown away
                end
            endcase
        end
    end

endmodule

//--- hdl/sem_inject_seq.sv
`timescale 1ns/1ps

module sem_inject_seq (
    input  logic                                    clk66m,
    input  logic                                    rst_66m,
    input  logic                                    inject_start,
    input  logic [sys_monitor_pkg::INJ_STROBES-1:0] inject_strobe_sel,
    input  logic [sys_monitor_pkg::INJ_ADDR_W-1:0]  inject_addr,
    output logic                                    inject_strobe,
    output logic [sys_monitor_pkg::INJ_ADDR_W-1:0]  inject_address
);
    import sys_monitor_pkg::*;

    // Each window is a 4 cycle gap followed by a 2 cycle strobe
    localparam int GAP_LEN = 4;
    localparam int WIN_LEN = 2;
    localparam int STEP    = GAP_LEN + WIN_LEN;
    localparam int SEQ_LEN = STEP * INJ_STROBES + 1;   // 19 stages for three windows

    logic               start_q;
    logic               start_edge;
    logic [SEQ_LEN-1:0] seq_sr;     // Bit 0 holds the fresh edge

    // ************************************************************
    // Edge detect and sequence shift register
    // ************************************************************
    assign start_edge = inject_start & ~start_q;

    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            start_q <= 1'b0;
            seq_sr  <= '0;
        end else begin
            start_q <= inject_start;
            seq_sr  <= {seq_sr[SEQ_LEN-2:0], start_edge};
        end
    end

    // ************************************************************
    // Window decode
    // ************************************************************
    // Earlier windows take priority when two sequences overlap,
    // and inside a window the gap beats the strobe
    always_comb begin
        inject_strobe = 1'b0;
        for (int k = INJ_STROBES - 1; k >= 0; k--) begin
            if (|seq_sr[STEP*k + GAP_LEN + 1 +: WIN_LEN]) begin
                inject_strobe = inject_strobe_sel[k];   // Strobe only if selected
            end
            if (|seq_sr[STEP*k + 1 +: GAP_LEN]) begin
                inject_strobe = 1'b0;
            end
        end
    end

    // Address held valid for the whole sequence, zero when idle
    assign inject_address = (|seq_sr[SEQ_LEN-1:1]) ? inject_addr : '0;

endmodule

//--- hdl/seu_event_counter.sv
`timescale 1ns/1ps

module seu_event_counter #(
    parameter int COUNT_W = 16
) (
    input  logic               clk66m,
    input  logic               rst_66m,
    input  logic               status,
    input  logic               clear,
    output logic [COUNT_W-1:0] count
);

    logic               status_q1;
    logic               status_q2;
    logic               status_edge;
    logic [COUNT_W-1:0] event_cnt;

    // One count per rising edge, a held level counts once
    assign status_edge = status_q1 & ~status_q2;

    always_ff @(posedge clk66m or posedge rst_66m) begin
        if (rst_66m) begin
            status_q1 <= 1'b0;
            status_q2 <= 1'b0;
            event_cnt <= '0;
            count     <= '0;
        end else begin
            status_q1 <= status;
            status_q2 <= status_q1;
            if (clear) begin
                // Clear wins over a coincident edge
                event_cnt <= '0;
                count     <= '0;
            end else begin
                if (status_edge) begin
                    event_cnt <= event_cnt + 1'b1;
                end
                count <= event_cnt;     // Output stage, one cycle behind
            end
        end
    end

endmodule

//--- hdl/sys_monitor_pkg.sv
package sys_monitor_pkg;

    // ************************************************************
    // Widths shared by the monitor blocks
    // ************************************************************
    localparam int INJ_ADDR_W  = 40;    // Scrubber injection address
    localparam int INJ_STROBES = 3;     // Strobe windows per sequence
    localparam int READING_W   = 12;    // Kept MSBs of one ADC result
    localparam int DRP_ADDR_W  = 7;
    localparam int DRP_DATA_W  = 16;

    // Poll slots, walked in this order by the sensor poller
    typedef enum logic [2:0] {
        chan_temperature,
        chan_vccint,
        chan_vccaux,
        chan_vccbram,
        chan_vpvn,
        chan_vrefp,
        chan_vrefn,
        chan_unused
    } sensor_chan_e;

    // ************************************************************
    // Slot to ADC status register address
    // ************************************************************
    // VCCBRAM sits at 0x06, out of order with the rest
    function automatic logic [DRP_ADDR_W-1:0] sensor_drp_addr(input sensor_chan_e chan);
        logic [DRP_ADDR_W-1:0] addr;
        case (chan)
            chan_temperature: addr = 7'h00;
            chan_vccint:      addr = 7'h01;
            chan_vccaux:      addr = 7'h02;
            chan_vccbram:     addr = 7'h06;
            chan_vpvn:        addr = 7'h03;
            chan_vrefp:       addr = 7'h04;
            chan_vrefn:       addr = 7'h05;
            default:          addr = 7'h00;   // Idle slot reads temperature again
        endcase
        return addr;
    endfunction

endpackage

//--- hdl/sys_monitor_top.sv
`timescale 1ns/1ps

module sys_monitor_top #(
    parameter int COUNT_W   = 16,
    parameter int DIV_W     = 16,
    parameter int DEN_DELAY = 255
) (
    input  logic                                    clk66m,
    input  logic                                    rst_66m,

    // Fault injection towards the scrubber
    input  logic                                    inject_start,
    input  logic [sys_monitor_pkg::INJ_STROBES-1:0] inject_strobe_sel,
    input  logic [sys_monitor_pkg::INJ_ADDR_W-1:0]  inject_addr,
    output logic                                    inject_strobe,
    output logic [sys_monitor_pkg::INJ_ADDR_W-1:0]  inject_address,

    // Scrubber status and event counts
    input  logic                                    status_correction,
    input  logic                                    status_uncorrectable,
    input  logic                                    seu_count_reset,
    output logic [COUNT_W-1:0]                      seu_enable_count,
    output logic [COUNT_W-1:0]                      seu_disable_count,

    // ADC reconfiguration port
    output logic                                    drp_den,
    output logic [sys_monitor_pkg::DRP_ADDR_W-1:0]  drp_daddr,
    input  logic                                    drp_drdy,
    input  logic [sys_monitor_pkg::DRP_DATA_W-1:0]  drp_do,

    // Sensor readings
    output logic [sys_monitor_pkg::READING_W-1:0]   temperature,
    output logic [sys_monitor_pkg::READING_W-1:0]   vccint,
    output logic [sys_monitor_pkg::READING_W-1:0]   vccaux,
    output logic [sys_monitor_pkg::READING_W-1:0]   vccbram,
    output logic [sys_monitor_pkg::READING_W-1:0]   vpvn,
    output logic [sys_monitor_pkg::READING_W-1:0]   vrefp,
    output logic [sys_monitor_pkg::READING_W-1:0]   vrefn
);

    // ************************************************************
    // Configuration memory side
    // ************************************************************
    sem_inject_seq u_inject_seq (
        .clk66m            (clk66m),
        .rst_66m           (rst_66m),
        .inject_start      (inject_start),
        .inject_strobe_sel (inject_strobe_sel),
        .inject_addr       (inject_addr),
        .inject_strobe     (inject_strobe),
        .inject_address    (inject_address)
    );

    // Corrected upsets
    seu_event_counter #(
        .COUNT_W (COUNT_W)
    ) u_correction_count (
        .clk66m  (clk66m),
        .rst_66m (rst_66m),
        .status  (status_correction),
        .clear   (seu_count_reset),
        .count   (seu_enable_count)
    );

    // Upsets the scrubber could not fix
    seu_event_counter #(
        .COUNT_W (COUNT_W)
    ) u_uncorrectable_count (
        .clk66m  (clk66m),
        .rst_66m (rst_66m),
        .status  (status_uncorrectable),
        .clear   (seu_count_reset),
        .count   (seu_disable_count)
    );

    // ************************************************************
    // Temperature and supply monitor
    // ************************************************************
    adc_sensor_poller #(
        .DIV_W     (DIV_W),
        .DEN_DELAY (DEN_DELAY)
    ) u_sensor_poller (
        .clk66m      (clk66m),
        .rst_66m     (rst_66m),
        .drp_den     (drp_den),
        .drp_daddr   (drp_daddr),
        .drp_drdy    (drp_drdy),
        .drp_do      (drp_do),
        .temperature (temperature),
        .vccint      (vccint),
        .vccaux      (vccaux),
        .vccbram     (vccbram),
        .vpvn        (vpvn),
        .vrefp       (vrefp),
        .vrefn       (vrefn)
    );

endmodule

//--- list.f
hdl/sys_monitor_pkg.sv
hdl/sem_inject_seq.sv
hdl/seu_event_counter.sv
hdl/adc_sensor_poller.sv
hdl/sys_monitor_top.sv
tests/tb_adc_drp_model.sv
tests/sys_monitor_asserts.sv
tests/tb_sys_monitor.sv

//--- tests/sys_monitor_asserts.sv
`timescale 1ns/1ps

module sys_monitor_asserts #(
    parameter int COUNT_W = 16
) (
    input logic                                   clk66m,
    input logic                                   rst_66m,
    input logic                                   inject_strobe,
    input logic [sys_monitor_pkg::INJ_ADDR_W-1:0] inject_address,
    input logic                                   drp_den,
    input logic                                   seu_count_reset,
    input logic [COUNT_W-1:0]                     seu_enable_count,
    input logic [COUNT_W-1:0]                     seu_disable_count
);

    int assert_failures = 0;    // Summed into the run result

    // ************************************************************
    // ADC port and injection
    // ************************************************************
    a_den_single: assert property (@(posedge clk66m) disable iff (rst_66m)
        drp_den |=> !drp_den)
        else begin
            assert_failures++;
            $error("drp_den high for more than one cycle");
        end

    // Scrubber must never see a strobe without an address
    a_strobe_addr: assert property (@(posedge clk66m) disable iff (rst_66m)
        inject_strobe |-> (inject_address != '0))
        else begin
            assert_failures++;
            $error("inject_strobe high with zero inject_address");
        end

    // ************************************************************
    // Event counts only fall after a clear
    // ************************************************************
    a_enable_count_up: assert property (@(posedge clk66m) disable iff (rst_66m)
        (seu_enable_count < $past(seu_enable_count)) |-> $past(seu_count_reset))
        else begin
            assert_failures++;
            $error("seu_enable_count dropped without seu_count_reset");
        end

    a_disable_count_up: assert property (@(posedge clk66m) disable iff (rst_66m)
        (seu_disable_count < $past(seu_disable_count)) |-> $past(seu_count_reset))
        else begin
            assert_failures++;
            $error("seu_disable_count dropped without seu_count_reset");
        end

endmodule

//--- tests/tb_adc_drp_model.sv
`timescale 1ns/1ps

module tb_adc_drp_model #(
    parameter int LATENCY = 4
) (
    input  logic                                   clk66m,
    input  logic                                   rst_66m,
    input  logic                                   drp_den,
    input  logic [sys_monitor_pkg::DRP_ADDR_W-1:0] drp_daddr,
    output logic                                   drp_drdy,
    output logic [sys_monitor_pkg::DRP_DATA_W-1:0] drp_do
);
    import sys_monitor_pkg::*;

    localparam logic [11:0] RESULT_BASE = 12'hA00;

    int                    visits [2**DRP_ADDR_W];  // Requests seen per address
    logic [LATENCY-1:0]    busy_pipe;
    logic [DRP_DATA_W-1:0] data_pipe [LATENCY];

    initial begin
        drp_drdy  = 1'b0;
        drp_do    = '0;
        busy_pipe = '0;
        foreach (visits[a]) begin
            visits[a] = 0;
        end
    end

    // Request taken at the edge, answer driven just after a later edge
    always @(posedge clk66m) begin
        int i;
        if (rst_66m) begin
            busy_pipe = '0;
        end else begin
            busy_pipe = {busy_pipe[LATENCY-2:0], drp_den};
            for (i = LATENCY - 1; i > 0; i--) begin
                data_pipe[i] = data_pipe[i-1];
            end
            data_pipe[0] = {RESULT_BASE + 12'(drp_daddr) + 12'(16 * visits[drp_daddr]), 4'hF};
            if (drp_den) begin
                visits[drp_daddr]++;
            end
        end
        #2;
        drp_drdy = busy_pipe[LATENCY-1];
        drp_do   = busy_pipe[LATENCY-1] ? data_pipe[LATENCY-1] : '0;  // Data only with drdy
    end

endmodule

//--- tests/tb_sys_monitor.sv
`timescale 1ns/1ps

module tb_sys_monitor;
    import sys_monitor_pkg::*;

    localparam int COUNT_W     = 16;
    localparam int DIV_W       = 6;
    localparam int DEN_DELAY   = 15;
    localparam int SLOTS       = 8;
    localparam int POLL_PERIOD = 1 << DIV_W;
    localparam int INJECT_RUNS = 4;
    // Rough test lengths in cycles, watchdog gets three times their sum
    localparam int TEST_CYCLES = 10 + INJECT_RUNS * 25 + 2 * 8 * 12 + 20
                                 + 3 * SLOTS * POLL_PERIOD;
    localparam int WATCHDOG_CYCLES = 3 * TEST_CYCLES;

    logic                   clk66m = 1'b0;
    logic                   rst_66m;
    logic                   inject_start;
    logic [INJ_STROBES-1:0] inject_strobe_sel;
    logic [INJ_ADDR_W-1:0]  inject_addr;
    logic                   inject_strobe;
    logic [INJ_ADDR_W-1:0]  inject_address;
    logic                   status_correction;
    logic                   status_uncorrectable;
    logic                   seu_count_reset;
    logic [COUNT_W-1:0]     seu_enable_count;
    logic [COUNT_W-1:0]     seu_disable_count;
    logic                   drp_den;
    logic [DRP_ADDR_W-1:0]  drp_daddr;
    logic                   drp_drdy;
    logic [DRP_DATA_W-1:0]  drp_do;
    logic [READING_W-1:0]   temperature;
    logic [READING_W-1:0]   vccint;
    logic [READING_W-1:0]   vccaux;
    logic [READING_W-1:0]   vccbram;
    logic [READING_W-1:0]   vpvn;
    logic [READING_W-1:0]   vrefp;
    logic [READING_W-1:0]   vrefn;

    integer      seed;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          resp_seen = 0;
    int unsigned cycle_no = 0;
    int          den_addr [$];
    int unsigned den_cycle [$];
    int          slot_addr [SLOTS] = '{0, 1, 2, 6, 3, 4, 5, 0};
    string       reading_name [7] = '{"temperature", "vccint", "vccaux", "vccbram",
                                      "vpvn", "vrefp", "vrefn"};

    sys_monitor_top #(
        .COUNT_W   (COUNT_W),
        .DIV_W     (DIV_W),
        .DEN_DELAY (DEN_DELAY)
    ) DUT (.*);

    tb_adc_drp_model u_adc_model (.*);

    bind sys_monitor_top sys_monitor_asserts #(.COUNT_W(COUNT_W)) u_asserts (
        .clk66m            (clk66m),
        .rst_66m           (rst_66m),
        .inject_strobe     (inject_strobe),
        .inject_address    (inject_address),
        .drp_den           (drp_den),
        .seu_count_reset   (seu_count_reset),
        .seu_enable_count  (seu_enable_count),
        .seu_disable_count (seu_disable_count)
    );

    always #10 clk66m = ~clk66m;

    // Log of read enables and ADC answers
    always @(posedge clk66m) begin
        cycle_no++;
        if (!rst_66m && drp_den) begin
            den_addr.push_back(drp_daddr);
            den_cycle.push_back(cycle_no);
        end
        if (!rst_66m && drp_drdy) begin
            resp_seen++;
        end
    end

    // ************************************************************
    // Helpers
    // ************************************************************
    task automatic advance_clock();
        @(posedge clk66m);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERR %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic drive_status(input int line, input logic value);
        if (line == 0) begin
            status_correction = value;
        end else begin
            status_uncorrectable = value;
        end
    endtask

    function automatic logic [COUNT_W-1:0] count_of_line(input int line);
        return (line == 0) ? seu_enable_count : seu_disable_count;
    endfunction

    function automatic logic [READING_W-1:0] reading_of(input int slot);
        case (slot)
            0:       return temperature;
            1:       return vccint;
            2:       return vccaux;
            3:       return vccbram;
            4:       return vpvn;
            5:       return vrefp;
            default: return vrefn;
        endcase
    endfunction

    // Strobe k spans the two cycles after edge E+5+6k, if its select bit is set
    function automatic logic expected_strobe(input int n, input logic [INJ_STROBES-1:0] sel);
        int k;
        expected_strobe = 1'b0;
        for (k = 0; k < INJ_STROBES; k++) begin
            if (n == 6 * k + 5 || n == 6 * k + 6) expected_strobe = sel[k];
        end
    endfunction

    // One status pulse, checking the two cycle count latency on the way
    task automatic pulse_status(input int line, input int len, input int gap, input int expected);
        int    i;
        string name;
        name = (line == 0) ? "seu_enable_count" : "seu_disable_count";
        drive_status(line, 1'b1);
        for (i = 0; i < len + gap; i++) begin
            advance_clock();
            if (i == len - 1) drive_status(line, 1'b0);
            @(negedge clk66m);
            if (i == 1 && count_of_line(line) !== expected - 1) begin
                report_mismatch(name, expected - 1, count_of_line(line));
            end
            if (i >= 2 && count_of_line(line) !== expected) begin
                report_mismatch(name, expected, count_of_line(line));
            end
        end
        advance_clock();
    endtask

    // ************************************************************
    // Tests
    // ************************************************************
    task automatic test_reset_state();
        int errs_before;
        int slot;
        errs_before = errors;
        @(negedge clk66m);
        if (inject_strobe !== 1'b0) report_mismatch("inject_strobe", 0, inject_strobe);
        if (drp_den !== 1'b0) report_mismatch("drp_den", 0, drp_den);
        if (seu_enable_count !== '0) report_mismatch("seu_enable_count", 0, seu_enable_count);
        if (seu_disable_count !== '0) report_mismatch("seu_disable_count", 0, seu_disable_count);
        for (slot = 0; slot < 7; slot++) begin
            if (reading_of(slot) !== '0) begin
                report_mismatch(reading_name[slot], 0, reading_of(slot));
            end
        end
        advance_clock();
        close_test("reset", errs_before);
    endtask

    task automatic test_injection();
        int                     errs_before;
        int                     run;
        int                     n;
        logic [INJ_STROBES-1:0] sel;
        logic [INJ_ADDR_W-1:0]  addr;
        logic [INJ_ADDR_W-1:0]  exp_addr;
        errs_before = errors;
        for (run = 0; run < INJECT_RUNS; run++) begin
            sel  = $random(seed);
            addr = {$random(seed), $random(seed)};
            if (addr == '0) addr = 40'h1;
            inject_strobe_sel = sel;
            inject_addr       = addr;
            inject_start      = 1'b1;
            @(negedge clk66m);
            if (inject_address !== '0) report_mismatch("inject_address", 0, inject_address);
            for (n = 0; n <= 20; n++) begin
                advance_clock();            // After edge E+n
                @(negedge clk66m);
                exp_addr = (n >= 1 && n <= 18) ? addr : '0;
                if (inject_address !== exp_addr) begin
                    report_mismatch("inject_address", exp_addr, inject_address);
                end
                if (inject_strobe !== expected_strobe(n, sel)) begin
                    report_mismatch("inject_strobe", expected_strobe(n, sel), inject_strobe);
                end
            end
            advance_clock();
            inject_start = 1'b0;
            repeat (2) advance_clock();
        end
        close_test("injection", errs_before);
    endtask

    task automatic test_event_counting();
        int errs_before;
        int line;
        int i;
        int n_events;
        errs_before = errors;
        seu_count_reset = 1'b1;
        advance_clock();
        seu_count_reset = 1'b0;
        advance_clock();
        for (line = 0; line < 2; line++) begin
            n_events = 3 + $unsigned($random(seed)) % 4;
            for (i = 1; i <= n_events; i++) begin
                pulse_status(line, 1 + $unsigned($random(seed)) % 4,
                             2 + $unsigned($random(seed)) % 3, i);
            end
            pulse_status(line, 12, 3, n_events + 1);   // Long level, one event
            @(negedge clk66m);
            if (count_of_line(line) !== n_events + 1) begin
                report_mismatch(line ? "seu_disable_count" : "seu_enable_count",
                                n_events + 1, count_of_line(line));
            end
            if (line == 0 && seu_disable_count !== '0) begin
                report_mismatch("seu_disable_count", 0, seu_disable_count);
            end
            advance_clock();
        end
        close_test("event counting", errs_before);
    endtask

    task automatic test_clear_priority();
        int errs_before;
        int i;
        errs_before = errors;
        status_correction    = 1'b1;
        status_uncorrectable = 1'b1;
        seu_count_reset      = 1'b1;
        for (i = 0; i < 8; i++) begin
            advance_clock();
            if (i == 3) seu_count_reset = 1'b0;  // Held past the counter's edge cycle
            @(negedge clk66m);
            if (i >= 1 && seu_enable_count !== '0) begin
                report_mismatch("seu_enable_count", 0, seu_enable_count);
            end
            if (i >= 1 && seu_disable_count !== '0) begin
                report_mismatch("seu_disable_count", 0, seu_disable_count);
            end
        end
        advance_clock();
        status_correction    = 1'b0;
        status_uncorrectable = 1'b0;
        repeat (2) advance_clock();
        close_test("clear priority", errs_before);
    endtask

    task automatic test_sensor_readings();
        int                   errs_before;
        int                   target;
        int                   cycles;
        int                   n;
        int                   slot;
        int                   visits [2**DRP_ADDR_W];
        logic [READING_W-1:0] exp_reading [7];
        errs_before = errors;
        target = resp_seen + 2 * SLOTS;
        cycles = 0;
        while (resp_seen < target && cycles < 3 * SLOTS * POLL_PERIOD) begin
            advance_clock();
            cycles++;
        end
        if (resp_seen < target) begin
            $display("Sensor readings: ADC answers stopped, %0d of %0d seen",
                     resp_seen, target);
            errors++;
        end
        @(negedge clk66m);
        foreach (visits[a]) visits[a] = 0;
        foreach (exp_reading[s]) exp_reading[s] = '0;
        // Slot steps off temperature on the first edge after reset
        for (n = 0; n < resp_seen; n++) begin
            slot = (n + 1) % SLOTS;
            if (slot < 7) begin
                exp_reading[slot] = 12'hA00 + 12'(slot_addr[slot])
                                    + 12'(16 * visits[slot_addr[slot]]);
            end
            visits[slot_addr[slot]]++;
        end
        for (slot = 0; slot < 7; slot++) begin
            if (reading_of(slot) !== exp_reading[slot]) begin
                report_mismatch(reading_name[slot], exp_reading[slot], reading_of(slot));
            end
        end
        advance_clock();
        close_test("sensor readings", errs_before);
    endtask

    task automatic test_address_pacing();
        int errs_before;
        int n;
        errs_before = errors;
        if (den_addr.size() < 2 * SLOTS + 1) begin
            $display("Address map: only %0d read enables seen", den_addr.size());
            errors++;
        end
        for (n = 0; n < den_addr.size(); n++) begin
            if (den_addr[n] !== slot_addr[(n + 1) % SLOTS]) begin
                report_mismatch("drp_daddr", slot_addr[(n + 1) % SLOTS], den_addr[n]);
            end
            if (n > 0 && den_cycle[n] - den_cycle[n-1] != POLL_PERIOD) begin
                report_mismatch("drp_den spacing", POLL_PERIOD, den_cycle[n] - den_cycle[n-1]);
            end
        end
        close_test("address map and pacing", errs_before);
    endtask

    // ************************************************************
    // Main sequence and watchdog
    // ************************************************************
    initial begin
        int assert_fails;
        seed                 = 32'h88b8_eea6;
        rst_66m              = 1'b1;
        inject_start         = 1'b0;
        inject_strobe_sel    = '0;
        inject_addr          = '0;
        status_correction    = 1'b0;
        status_uncorrectable = 1'b0;
        seu_count_reset      = 1'b0;
        repeat (3) @(posedge clk66m);
        #2;
        rst_66m = 1'b0;
        test_reset_state();
        test_injection();
        test_event_counting();
        test_clear_priority();
        test_sensor_readings();
        test_address_pacing();
        assert_fails = DUT.u_asserts.assert_failures;
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk66m);
        $display("Watchdog: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule
